//--- logic/store_pkg.sv
`default_nettype none

package store_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Word geometry.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int WORD_BITS   = 32;                 // Data and address width.
    localparam int BYTE_LANES  = WORD_BITS / 8;      // Bytes per word.
    localparam int OFFSET_BITS = $clog2(BYTE_LANES); // Byte offset inside a word.

    typedef logic [WORD_BITS-1:0] data_word_t;       // Also carries addresses.

    // Size of a store as issued by the core.
    typedef enum logic [1:0] {BYTE, HALF_WORD, WORD} store_width_t;

endpackage : store_pkg

`default_nettype wire

//--- logic/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // Store controller states.
    typedef enum logic [1:0] {
        IDLE,          // Wait for a buffered store, send the lookup.
        OUTCOME,       // Cache result is back, hit or miss.
        WRITE_THROUGH  // Wait for external memory.
    } store_fsm_t;

    // Field select of a cache write, one bit per array.
    typedef struct packed {
        logic data;   // Merge write data by byte enable.
        logic valid;  // Load valid bit from status_valid.
        logic dirty;  // Load dirty bit from status_dirty.
    } cache_field_t;

endpackage : cache_pkg

`default_nettype wire

//--- logic/store_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module store_buffer
    import store_pkg::*;
#(
    parameter int BUFFER_DEPTH = 4
) (
    input  wire logic         clk_i,
    input  wire logic         rst_n_i,

    // Push side, from the core.
    input  wire logic         push_i,
    input  wire data_word_t   push_address_i,
    input  wire data_word_t   push_data_i,
    input  wire store_width_t push_width_i,
    output logic              full_o,

    // Head entry, toward the controller.
    input  wire logic         pop_i,
    output logic              valid_o,
    output data_word_t        head_address_o,
    output data_word_t        head_data_o,
    output store_width_t      head_width_o
);

    localparam int PTR_BITS   = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
    localparam int COUNT_BITS = $clog2(BUFFER_DEPTH + 1);

    // Entry storage, payload only.
    data_word_t   address_q [BUFFER_DEPTH];
    data_word_t   data_q    [BUFFER_DEPTH];
    store_width_t width_q   [BUFFER_DEPTH];

    logic [PTR_BITS-1:0]   wr_ptr_q, rd_ptr_q;
    logic [COUNT_BITS-1:0] count_q;
    logic                  push_ok, pop_ok;

    // Pointer increment with wrap, depth need not be a power of two.
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(BUFFER_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == COUNT_BITS'(BUFFER_DEPTH));
    assign valid_o = (count_q != '0);
    assign push_ok = push_i && !full_o;   // A push into a full queue is dropped.
    assign pop_ok  = pop_i && valid_o;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointers and occupancy.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (pop_ok)  rd_ptr_q <= next_ptr(rd_ptr_q);
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Both or neither keep the count.
            endcase
        end
    end

    // Entry write at the tail.
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            address_q[wr_ptr_q] <= push_address_i;
            data_q[wr_ptr_q]    <= push_data_i;
            width_q[wr_ptr_q]   <= push_width_i;
        end
    end

    // Head is held until popped.
    assign head_address_o = address_q[rd_ptr_q];
    assign head_data_o    = data_q[rd_ptr_q];
    assign head_width_o   = width_q[rd_ptr_q];

    // Controller only pops a store it has been offered.
    pop_when_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> valid_o)
        else $error("Store buffer popped while empty.");

    // Core must hold a store while the queue is full.
    push_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> !full_o)
        else $error("Store dropped on a push into a full buffer.");

endmodule : store_buffer

`default_nettype wire

//--- logic/store_controller.sv
`timescale 1ns/1ps
`default_nettype none

module store_controller
    import store_pkg::*, cache_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         rst_n_i,
    input  wire logic         halt_i,

    // Head of the store buffer.
    input  wire logic         request_i,
    input  wire data_word_t   entry_address_i,
    input  wire data_word_t   entry_data_i,
    input  wire store_width_t entry_width_i,
    output logic              done_o,           // Pops the head.

    // Data cache side.
    output logic              lookup_o,
    input  wire logic         cache_hit_i,      // Valid one cycle after lookup.
    input  wire logic         cache_dirty_i,
    output cache_field_t      write_field_o,
    output logic              status_valid_o,
    output logic              status_dirty_o,
    output logic [BYTE_LANES-1:0] byte_enable_o,
    output data_word_t        write_data_o,
    output data_word_t        cache_address_o,

    // Write-through to external memory.
    output logic              mem_request_o,
    output data_word_t        mem_address_o,
    output data_word_t        mem_data_o,
    output store_width_t      mem_width_o,
    input  wire logic         mem_done_i
);

    store_fsm_t state_q, state_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte lane placement.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        byte_enable_o = '0;
        write_data_o  = '0;
        case (entry_width_i)
            BYTE: begin  // Shift by the full byte offset.
                byte_enable_o = BYTE_LANES'(1) << entry_address_i[OFFSET_BITS-1:0];
                write_data_o  = data_word_t'(entry_data_i[7:0])
                                << (8 * entry_address_i[OFFSET_BITS-1:0]);
            end
            HALF_WORD: begin  // Lower or upper pair by address bit 1.
                byte_enable_o = entry_address_i[1] ? 4'b1100 : 4'b0011;
                write_data_o  = data_word_t'(entry_data_i[15:0]) << (16 * entry_address_i[1]);
            end
            WORD: begin
                byte_enable_o = '1;
                write_data_o  = entry_data_i;
            end
            default: ;  // Unused encoding writes nothing.
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FSM.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else if (!halt_i) begin  // Halt freezes the state only.
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d        = state_q;
        done_o         = 1'b0;
        lookup_o       = 1'b0;
        write_field_o  = '0;
        status_valid_o = 1'b0;
        status_dirty_o = 1'b0;
        mem_request_o  = 1'b0;

        case (state_q)
            IDLE: begin
                if (request_i) begin
                    lookup_o = 1'b1;     // Hit and dirty return next cycle.
                    state_d  = OUTCOME;
                end
            end

            OUTCOME: begin
                if (cache_hit_i) begin
                    // Merge bytes, block becomes dirty and valid.
                    write_field_o  = '{data: 1'b1, valid: 1'b1, dirty: 1'b1};
                    status_valid_o = 1'b1;
                    status_dirty_o = 1'b1;
                    done_o         = 1'b1;
                    state_d        = IDLE;
                end else begin
                    mem_request_o = 1'b1;
                    state_d       = WRITE_THROUGH;
                    if (!cache_dirty_i) begin
                        write_field_o.valid = 1'b1;  // Invalidate a clean block.
                    end
                end
            end

            WRITE_THROUGH: begin
                if (mem_done_i) begin
                    done_o  = 1'b1;
                    state_d = IDLE;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    // Address and width go out straight from the head.
    assign cache_address_o = entry_address_i;
    assign mem_address_o   = entry_address_i;
    assign mem_width_o     = entry_width_i;
    assign mem_data_o      = write_data_o;  // Already lane shifted.

    // Unhalted request is a single pulse, then the FSM waits for memory.
    mem_request_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_request_o && !halt_i |=> !mem_request_o && (state_q == WRITE_THROUGH))
        else $error("Memory request held past its OUTCOME cycle.");

endmodule : store_controller

`default_nettype wire

//--- logic/store_data_cache.sv
`timescale 1ns/1ps
`default_nettype none

module store_data_cache
    import store_pkg::*, cache_pkg::*;
#(
    parameter int CACHE_SETS = 16
) (
    input  wire logic         clk_i,
    input  wire logic         rst_n_i,

    // Store port, driven by the controller.
    input  wire logic         lookup_i,
    input  wire data_word_t   address_i,
    input  wire cache_field_t write_field_i,
    input  wire logic         status_valid_i,
    input  wire logic         status_dirty_i,
    input  wire logic [BYTE_LANES-1:0] byte_enable_i,
    input  wire data_word_t   write_data_i,
    output logic              hit_o,
    output logic              dirty_o,

    // Load port.
    input  wire logic         load_request_i,
    input  wire data_word_t   load_address_i,
    output logic              load_hit_o,
    output data_word_t        load_data_o,

    // Block fill port.
    input  wire logic         fill_i,
    input  wire data_word_t   fill_address_i,
    input  wire data_word_t   fill_data_i
);

    localparam int INDEX_BITS = $clog2(CACHE_SETS);
    localparam int TAG_BITS   = WORD_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int INDEX_LSB  = OFFSET_BITS;
    localparam int TAG_LSB    = OFFSET_BITS + INDEX_BITS;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Arrays.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [TAG_BITS-1:0]   tag_q  [CACHE_SETS];
    data_word_t            data_q [CACHE_SETS];
    logic [CACHE_SETS-1:0] valid_bits_q;
    logic [CACHE_SETS-1:0] dirty_bits_q;

    // Address split, offset bits are ignored.
    logic [INDEX_BITS-1:0] store_index, load_index, fill_index;
    logic [TAG_BITS-1:0]   store_tag, load_tag, fill_tag;

    assign store_index = address_i[TAG_LSB-1:INDEX_LSB];
    assign store_tag   = address_i[WORD_BITS-1:TAG_LSB];
    assign load_index  = load_address_i[TAG_LSB-1:INDEX_LSB];
    assign load_tag    = load_address_i[WORD_BITS-1:TAG_LSB];
    assign fill_index  = fill_address_i[TAG_LSB-1:INDEX_LSB];
    assign fill_tag    = fill_address_i[WORD_BITS-1:TAG_LSB];

    // Status bits. The fill comes last so it wins on a shared set.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_bits_q <= '0;
            dirty_bits_q <= '0;
        end else begin
            if (write_field_i.valid) valid_bits_q[store_index] <= status_valid_i;
            if (write_field_i.dirty) dirty_bits_q[store_index] <= status_dirty_i;
            if (fill_i) begin
                valid_bits_q[fill_index] <= 1'b1;  // Filled block is valid and clean.
                dirty_bits_q[fill_index] <= 1'b0;
            end
        end
    end

    // Tag and data, written per byte on a store.
    always_ff @(posedge clk_i) begin
        if (write_field_i.data) begin
            for (int lane = 0; lane < BYTE_LANES; lane++) begin
                if (byte_enable_i[lane]) begin
                    data_q[store_index][lane*8 +: 8] <= write_data_i[lane*8 +: 8];
                end
            end
        end
        if (fill_i) begin
            tag_q[fill_index]  <= fill_tag;
            data_q[fill_index] <= fill_data_i;  // Whole block.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registered lookups.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            hit_o   <= 1'b0;
            dirty_o <= 1'b0;
        end else if (lookup_i) begin  // Result holds until the next lookup.
            hit_o   <= valid_bits_q[store_index] && (tag_q[store_index] == store_tag);
            dirty_o <= dirty_bits_q[store_index];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            load_hit_o <= 1'b0;
        end else begin
            load_hit_o <= load_request_i && valid_bits_q[load_index]
                          && (tag_q[load_index] == load_tag);
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_request_i) load_data_o <= data_q[load_index];
    end

endmodule : store_data_cache

`default_nettype wire

//--- logic/store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module store_unit
    import store_pkg::*, cache_pkg::*;
#(
    parameter int BUFFER_DEPTH = 4,
    parameter int CACHE_SETS   = 16
) (
    input  wire logic         clk_i,
    input  wire logic         rst_n_i,
    input  wire logic         halt_i,

    // Store issue from the core.
    input  wire logic         store_push_i,
    input  wire data_word_t   store_address_i,
    input  wire data_word_t   store_data_i,
    input  wire store_width_t store_width_i,
    output logic              store_full_o,

    // Write-through channel.
    output logic              mem_request_o,
    output data_word_t        mem_address_o,
    output data_word_t        mem_data_o,
    output store_width_t      mem_width_o,
    input  wire logic         mem_done_i,

    // Load lookup and block fill.
    input  wire logic         load_request_i,
    input  wire data_word_t   load_address_i,
    output logic              load_hit_o,
    output data_word_t        load_data_o,
    input  wire logic         fill_i,
    input  wire data_word_t   fill_address_i,
    input  wire data_word_t   fill_data_i
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Internal nets.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic                  buffer_valid, head_pop;    // Buffer to controller.
    data_word_t            head_address, head_data;
    store_width_t          head_width;
    logic                  lookup, cache_hit, cache_dirty;
    cache_field_t          write_field;
    logic                  status_valid, status_dirty;
    logic [BYTE_LANES-1:0] byte_enable;
    data_word_t            write_data, cache_address;

    store_buffer #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_store_buffer (
        .clk_i, .rst_n_i,
        .push_i (store_push_i), .push_address_i (store_address_i),
        .push_data_i (store_data_i), .push_width_i (store_width_i),
        .full_o (store_full_o), .pop_i (head_pop), .valid_o (buffer_valid),
        .head_address_o (head_address), .head_data_o (head_data),
        .head_width_o (head_width)
    );

    store_controller u_store_controller (
        .clk_i, .rst_n_i, .halt_i,
        .request_i (buffer_valid), .entry_address_i (head_address),
        .entry_data_i (head_data), .entry_width_i (head_width), .done_o (head_pop),
        .lookup_o (lookup), .cache_hit_i (cache_hit), .cache_dirty_i (cache_dirty),
        .write_field_o (write_field), .status_valid_o (status_valid),
        .status_dirty_o (status_dirty), .byte_enable_o (byte_enable),
        .write_data_o (write_data), .cache_address_o (cache_address),
        .mem_request_o, .mem_address_o, .mem_data_o, .mem_width_o, .mem_done_i
    );

    store_data_cache #(
        .CACHE_SETS (CACHE_SETS)
    ) u_store_data_cache (
        .clk_i, .rst_n_i,
        .lookup_i (lookup), .address_i (cache_address), .write_field_i (write_field),
        .status_valid_i (status_valid), .status_dirty_i (status_dirty),
        .byte_enable_i (byte_enable), .write_data_i (write_data),
        .hit_o (cache_hit), .dirty_o (cache_dirty),
        .load_request_i, .load_address_i, .load_hit_o, .load_data_o,
        .fill_i, .fill_address_i, .fill_data_i
    );

endmodule : store_unit

`default_nettype wire

//--- dv/memory_model.sv
`timescale 1ns/1ps
`default_nettype none

module memory_model
    import store_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         rst_n_i,
    input  wire logic         request_i,     // One-cycle write-through pulse.
    input  wire data_word_t   address_i,
    input  wire data_word_t   data_i,        // Already in its byte lanes.
    input  wire store_width_t width_i,
    output logic              done_o
);

    localparam int WORDS = 64;                // Covers byte addresses 0x00 to 0xFF.

    data_word_t   words       [WORDS];        // Reference memory contents.
    data_word_t   log_address [WORDS];        // Write log in arrival order.
    data_word_t   log_data    [WORDS];
    store_width_t log_width   [WORDS];
    int           write_count;

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            words[i] = (data_word_t'(i) * 32'h0101_0101) ^ 32'hA5C3_0F69;  // Per-word pattern.
        end
        write_count = 0;
        done_o      = 1'b0;
    end

    // Merge one write into the reference word by byte lanes, then log it.
    task automatic apply_write(input data_word_t address, input data_word_t data,
                               input store_width_t width);
        logic [3:0] lanes;
        case (width)
            BYTE:      lanes = 4'b0001 << address[1:0];
            HALF_WORD: lanes = address[1] ? 4'b1100 : 4'b0011;
            default:   lanes = 4'b1111;
        endcase
        for (int lane = 0; lane < 4; lane++) begin
            if (lanes[lane]) words[address[7:2]][lane*8 +: 8] = data[lane*8 +: 8];
        end
        if (write_count < WORDS) begin
            log_address[write_count] = address;
            log_data[write_count]    = data;
            log_width[write_count]   = width;
        end
        write_count++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request service.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always begin : serve_requests
        data_word_t   address, data;
        store_width_t width;
        int           delay;
        @(negedge clk_i);                     // Request is stable mid-cycle.
        if (rst_n_i && request_i) begin
            address = address_i;
            data    = data_i;
            width   = width_i;
            delay   = 3 + int'($urandom % 4); // 3 to 6 cycles.
            repeat (delay) @(negedge clk_i);
            done_o = 1'b1;
            @(posedge clk_i);                 // Controller pops here.
            apply_write(address, data, width);
            @(negedge clk_i);
            done_o = 1'b0;
        end
    end

endmodule : memory_model

`default_nettype wire

//--- dv/store_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module store_unit_tb
    import store_pkg::*;
;

    localparam int BUFFER_DEPTH = 4;
    localparam int CACHE_SETS   = 16;
    localparam int CYCLE_LIMIT  = 4000;  // About four times the summed worst case.
    localparam int HIT_CYCLES   = 4;     // Two-cycle hit plus margin.
    localparam int WAIT_LIMIT   = 300;   // Bound on any single wait loop.

    logic         clk_i, rst_n_i, halt_i;
    logic         store_push_i, store_full_o;
    data_word_t   store_address_i, store_data_i;
    store_width_t store_width_i;
    logic         mem_request_o, mem_done;
    data_word_t   mem_address_o, mem_data_o;
    store_width_t mem_width_o;
    logic         load_request_i, load_hit_o, fill_i;
    data_word_t   load_address_i, load_data_o, fill_address_i, fill_data_i;

    int   error_count = 0;
    int   check_count = 0;
    int   tests_run   = 0;
    int   cycle_count = 0;
    logic full_seen;                     // Set when a push had to wait.

    store_unit #(
        .BUFFER_DEPTH (BUFFER_DEPTH),
        .CACHE_SETS   (CACHE_SETS)
    ) u_dut (
        .clk_i, .rst_n_i, .halt_i,
        .store_push_i, .store_address_i, .store_data_i, .store_width_i, .store_full_o,
        .mem_request_o, .mem_address_o, .mem_data_o, .mem_width_o, .mem_done_i (mem_done),
        .load_request_i, .load_address_i, .load_hit_o, .load_data_o,
        .fill_i, .fill_address_i, .fill_data_i
    );

    memory_model u_memory (
        .clk_i, .rst_n_i,
        .request_i (mem_request_o), .address_i (mem_address_o),
        .data_i (mem_data_o), .width_i (mem_width_o), .done_o (mem_done)
    );

    always #20 clk_i = ~clk_i;           // 40 ns period.

    // Run limit.
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles, controller state %0d, %0d writes",
                     cycle_count, u_dut.u_store_controller.state_q, u_memory.write_count);
            $display("Something failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers. All start and end on a falling edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(input string name, input data_word_t actual,
                               input data_word_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH at %0t ns: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        $display("%-22s finished, %0d errors", name, error_count - start_errors);
    endtask

    // Push one store, holding it while the queue is full.
    task automatic push_store(input data_word_t address, input data_word_t data,
                              input store_width_t width);
        int waited;
        waited = 0;
        while (store_full_o && waited < WAIT_LIMIT) begin
            full_seen = 1'b1;
            @(negedge clk_i);
            waited++;
        end
        if (store_full_o) begin
            error_count++;
            $display("Store to 0x%08h never accepted, buffer stayed full", address);
        end else begin
            store_push_i    = 1'b1;
            store_address_i = address;
            store_data_i    = data;
            store_width_i   = width;
            @(negedge clk_i);
            store_push_i = 1'b0;
        end
    endtask

    task automatic wait_writes(input int target);
        int waited;
        waited = 0;
        while (u_memory.write_count < target && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (u_memory.write_count < target) begin
            error_count++;
            $display("Memory write count stuck at %0d, expected %0d",
                     u_memory.write_count, target);
        end
    endtask

    task automatic store_and_wait(input data_word_t address, input data_word_t data,
                                  input store_width_t width);
        int base;
        base = u_memory.write_count;
        push_store(address, data, width);
        wait_writes(base + 1);
    endtask

    // A hit has a fixed latency, so a short wait after the queue drains is enough.
    // Any memory request in that window means the store was taken as a miss.
    task automatic settle_hit(output logic request_seen);
        int waited;
        waited       = 0;
        request_seen = 1'b0;
        while (store_full_o && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        repeat (HIT_CYCLES) begin
            if (mem_request_o) request_seen = 1'b1;
            @(negedge clk_i);
        end
    endtask

    task automatic load_word(input data_word_t address, output logic hit,
                             output data_word_t data);
        load_request_i = 1'b1;
        load_address_i = address;
        @(negedge clk_i);                // Result registered on the edge before.
        load_request_i = 1'b0;
        hit  = load_hit_o;
        data = load_data_o;
    endtask

    task automatic fill_block(input data_word_t address, input data_word_t data);
        fill_i         = 1'b1;
        fill_address_i = address;
        fill_data_i    = data;
        @(negedge clk_i);
        fill_i = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_miss_write_through();
        int         start_errors, base;
        logic       hit;
        data_word_t data;
        start_errors = error_count;
        base         = u_memory.write_count;
        store_and_wait(32'h0000_0010, 32'hCAFE_F00D, WORD);
        check_value("mem_address_o", u_memory.log_address[base], 32'h0000_0010);
        check_value("mem_data_o", u_memory.log_data[base], 32'hCAFE_F00D);
        check_value("mem_width_o", data_word_t'(u_memory.log_width[base]), data_word_t'(WORD));
        load_word(32'h0000_0010, hit, data);
        check_value("load_hit_o", data_word_t'(hit), 32'd0);  // Miss never allocates.
        finish_test("miss_write_through", start_errors);
    endtask

    task automatic test_lane_placement();
        int         start_errors;
        data_word_t expected;
        start_errors = error_count;
        expected     = u_memory.words[8];
        for (int k = 0; k < 4; k++) begin
            // Upper data bits are junk and must not reach memory.
            store_and_wait(32'h0000_0020 + k, {24'hFFFF_FF, 8'hB0 + 8'(k)}, BYTE);
            expected[k*8 +: 8] = 8'hB0 + 8'(k);
            check_value("memory byte lane", u_memory.words[8], expected);
        end
        expected = u_memory.words[9];
        store_and_wait(32'h0000_0024, 32'hDEAD_1234, HALF_WORD);
        expected[15:0] = 16'h1234;
        check_value("memory lower half", u_memory.words[9], expected);
        store_and_wait(32'h0000_0026, 32'hBEEF_5678, HALF_WORD);
        expected[31:16] = 16'h5678;
        check_value("memory upper half", u_memory.words[9], expected);
        finish_test("lane_placement", start_errors);
    endtask

    task automatic test_hit_merge();
        int         start_errors;
        logic       hit, request_seen;
        data_word_t data;
        start_errors = error_count;
        fill_block(32'h0000_0030, 32'h1122_3344);
        push_store(32'h0000_0032, 32'h0000_00EE, BYTE);
        settle_hit(request_seen);
        check_value("mem_request_o on hit", data_word_t'(request_seen), 32'd0);  // Stays local.
        load_word(32'h0000_0030, hit, data);
        check_value("load_hit_o", data_word_t'(hit), 32'd1);
        check_value("load_data_o", data, 32'h11EE_3344);
        finish_test("hit_merge", start_errors);
    endtask

    task automatic test_clean_dirty_miss();
        int         start_errors;
        logic       hit, request_seen;
        data_word_t data;
        start_errors = error_count;
        // Clean block, a conflicting miss invalidates it.
        fill_block(32'h0000_0014, 32'h1357_9BDF);
        store_and_wait(32'h0000_0054, 32'h2468_ACE0, WORD);
        load_word(32'h0000_0014, hit, data);
        check_value("load_hit_o clean", data_word_t'(hit), 32'd0);
        // Dirty block survives the conflicting miss.
        fill_block(32'h0000_0018, 32'h0F0F_0F0F);
        push_store(32'h0000_001B, 32'h0000_0077, BYTE);
        settle_hit(request_seen);
        check_value("mem_request_o on hit", data_word_t'(request_seen), 32'd0);
        store_and_wait(32'h0000_0058, 32'h8642_0ECA, WORD);
        load_word(32'h0000_0018, hit, data);
        check_value("load_hit_o dirty", data_word_t'(hit), 32'd1);
        check_value("load_data_o dirty", data, 32'h770F_0F0F);
        finish_test("clean_dirty_miss", start_errors);
    endtask

    task automatic test_back_pressure();
        int start_errors, base;
        start_errors = error_count;
        base         = u_memory.write_count;
        full_seen    = 1'b0;
        for (int k = 0; k < BUFFER_DEPTH + 2; k++) begin
            push_store(32'h0000_0080 + 4 * k, 32'h1000_0000 + k * 32'h0101, WORD);
        end
        wait_writes(base + BUFFER_DEPTH + 2);
        check_value("store_full_o seen", data_word_t'(full_seen), 32'd1);
        for (int k = 0; k < BUFFER_DEPTH + 2; k++) begin
            check_value("ordered address", u_memory.log_address[base + k],
                        32'h0000_0080 + 4 * k);
            check_value("ordered data", u_memory.log_data[base + k],
                        32'h1000_0000 + k * 32'h0101);
        end
        finish_test("back_pressure", start_errors);
    endtask

    task automatic test_halt();
        int   start_errors, base;
        logic request_seen;
        start_errors = error_count;
        base         = u_memory.write_count;
        request_seen = 1'b0;
        halt_i       = 1'b1;
        push_store(32'h0000_00A0, 32'h0BAD_BEEF, WORD);
        for (int k = 0; k < 20; k++) begin
            if (mem_request_o) request_seen = 1'b1;
            @(negedge clk_i);
        end
        check_value("mem_request_o under halt", data_word_t'(request_seen), 32'd0);
        check_value("write_count under halt", u_memory.write_count, base);
        halt_i = 1'b0;
        wait_writes(base + 1);
        check_value("memory word after halt", u_memory.words[40], 32'h0BAD_BEEF);
        finish_test("halt", start_errors);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        void'($urandom(78));             // One seed for the whole run.
        clk_i           = 1'b0;
        rst_n_i         = 1'b0;
        halt_i          = 1'b0;
        store_push_i    = 1'b0;
        store_address_i = '0;
        store_data_i    = '0;
        store_width_i   = BYTE;
        load_request_i  = 1'b0;
        load_address_i  = '0;
        fill_i          = 1'b0;
        fill_address_i  = '0;
        fill_data_i     = '0;
        full_seen       = 1'b0;
        repeat (16) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        check_value("store_full_o after reset", data_word_t'(store_full_o), 32'd0);
        check_value("mem_request_o after reset", data_word_t'(mem_request_o), 32'd0);
        check_value("load_hit_o after reset", data_word_t'(load_hit_o), 32'd0);

        test_miss_write_through();
        test_lane_placement();
        test_hit_merge();
        test_clean_dirty_miss();
        test_back_pressure();
        test_halt();

        $display("Tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : store_unit_tb

`default_nettype wire

//--- src.f
logic/store_pkg.sv
logic/cache_pkg.sv
logic/store_buffer.sv
logic/store_controller.sv
logic/store_data_cache.sv
logic/store_unit.sv
dv/memory_model.sv
dv/store_unit_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the store unit testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module store_unit_tb -o store_unit_sim

./obj_dir/store_unit_sim | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"
